/* hdl/control_unit.sv */
`timescale 1ns/100ps

module control_unit
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  opcode_t opcode,
  input  funct3_t funct3,
  input  logic    funct7_bad,
  output ctrl_t   ctrl
);

  ctrl_t raw;

  // ============================================================
  // Opcode table
  // ============================================================

  always_comb begin
    raw            = '0;
    raw.result_src = RES_ALU;
    raw.alu_src_a  = SRC_A_REG;
    raw.alu_src_b  = SRC_B_REG;
    case (opcode)
      OPC_LUI: begin
        raw.reg_write = 1'b1;
        raw.alu_src_a = SRC_A_ZERO;
        raw.alu_src_b = SRC_B_IMM;
      end
      OPC_AUIPC: begin
        raw.reg_write = 1'b1;
        raw.alu_src_a = SRC_A_PC;
        raw.alu_src_b = SRC_B_IMM;
      end
      OPC_JAL, OPC_JALR: begin
        raw.reg_write  = 1'b1;
        raw.jump       = 1'b1;
        raw.result_src = RES_PC_PLUS_4;
        raw.alu_src_a  = (opcode == OPC_JAL) ? SRC_A_PC : SRC_A_REG;  // Target base
        raw.alu_src_b  = SRC_B_IMM;
      end
      OPC_BRANCH: begin
        raw.branch  = 1'b1;
        raw.illegal = (funct3 == 3'b010) || (funct3 == 3'b011);  // No such compare
      end
      OPC_LOAD: begin
        raw.reg_write  = 1'b1;
        raw.result_src = RES_MEM;
        raw.alu_src_b  = SRC_B_IMM;
        raw.illegal    = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);  // LB..LHU only
      end
      OPC_STORE: begin
        raw.mem_write = 1'b1;
        raw.alu_src_b = SRC_B_IMM;
        raw.illegal   = funct3[2] || (funct3[1:0] == 2'b11);  // SB, SH, SW
      end
      OPC_OP_IMM: begin
        raw.reg_write = 1'b1;
        raw.alu_src_b = SRC_B_IMM;
        raw.illegal   = funct7_bad;
      end
      OPC_OP: begin
        raw.reg_write = 1'b1;
        raw.illegal   = funct7_bad;
      end
      default: raw.illegal = 1'b1;
    endcase
  end

  // Illegal instructions lose every side effect
  always_comb begin
    ctrl = raw;
    if (raw.illegal) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.jump      = 1'b0;
      ctrl.branch    = 1'b0;
    end
  end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
#(
  parameter bit REG_BYPASS = 1'b1
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  if_to_id_t if_to_id,
  input  wb_to_id_t wb,
  output logic      out_valid,
  output id_to_ex_t id_to_ex
);

  opcode_t   opcode;
  funct3_t   funct3;
  logic      funct7_bad;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm_ext;
  alu_op_t   alu_op;
  ctrl_t     ctrl;
  word_t     rd1;
  word_t     rd2;
  id_to_ex_t id_next;

  // ============================================================
  // Decode path
  // ============================================================

  instr_decoder u_instr_decoder (
    .instr      (if_to_id.instruction),
    .opcode     (opcode),
    .funct3     (funct3),
    .funct7_alt (),                      // Consumed inside for SUB and SRA
    .funct7_bad (funct7_bad),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm_ext    (imm_ext),
    .alu_op     (alu_op)
  );

  control_unit u_control_unit (
    .opcode     (opcode),
    .funct3     (funct3),
    .funct7_bad (funct7_bad),
    .ctrl       (ctrl)
  );

  register_file #(
    .REG_BYPASS (REG_BYPASS)
  ) u_register_file (
    .clk   (clk),
    .rst_n (rst_n),
    .rs1   (rs1),
    .rs2   (rs2),
    .wb    (wb),
    .rd1   (rd1),
    .rd2   (rd2)
  );

  always_comb begin
    id_next           = '0;
    id_next.ctrl      = ctrl;
    id_next.alu_op    = alu_op;
    id_next.funct3    = funct3;
    id_next.rd1       = rd1;
    id_next.rd2       = rd2;
    id_next.rs1       = rs1;
    id_next.rs2       = rs2;
    id_next.rd        = rd;
    id_next.imm_ext   = imm_ext;
    id_next.pc_cur    = if_to_id.pc_cur;
    id_next.pc_plus_4 = if_to_id.pc_plus_4;
  end

  // Decode-to-execute register, one cycle after the strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      id_to_ex  <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid)
        id_to_ex <= id_next;
    end
  end

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/100ps

module instr_decoder
  import rv_isa_pkg::*;
(
  input  instr_t    instr,
  output opcode_t   opcode,
  output funct3_t   funct3,
  output logic      funct7_alt,
  output logic      funct7_bad,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm_ext,
  output alu_op_t   alu_op
);

  logic [6:0] funct7;

  // ============================================================
  // Field slicing
  // ============================================================

  assign opcode     = opcode_t'(instr[6:0]);
  assign rd         = instr[11:7];
  assign funct3     = instr[14:12];
  assign rs1        = instr[19:15];
  assign rs2        = instr[24:20];
  assign funct7     = instr[31:25];
  assign funct7_alt = instr[30];

  // Only the two defined funct7 forms pass, the alternate one only on its own funct3
  always_comb begin
    funct7_bad = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == F7_ALT)
          funct7_bad = (funct3 != F3_ADD_SUB) && (funct3 != F3_SRL_SRA);
        else
          funct7_bad = (funct7 != F7_BASE);
      end
      OPC_OP_IMM: begin
        if (funct3 == F3_SLL)
          funct7_bad = (funct7 != F7_BASE);
        else if (funct3 == F3_SRL_SRA)
          funct7_bad = (funct7 != F7_BASE) && (funct7 != F7_ALT);
      end
      default: funct7_bad = 1'b0;
    endcase
  end

  // ============================================================
  // Immediate generation
  // ============================================================

  always_comb begin
    case (opcode)
      OPC_OP_IMM, OPC_LOAD, OPC_JALR:
        imm_ext = {{20{instr[31]}}, instr[31:20]};                       // I
      OPC_STORE:
        imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};          // S
      OPC_BRANCH:
        imm_ext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      OPC_LUI, OPC_AUIPC:
        imm_ext = {instr[31:12], 12'b0};                                 // U
      OPC_JAL:
        imm_ext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:
        imm_ext = '0;
    endcase
  end

  // ============================================================
  // ALU operation
  // ============================================================

  always_comb begin
    alu_op = ALU_ADD;  // Address math of loads, stores, jumps, AUIPC
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        case (funct3)
          F3_ADD_SUB: alu_op = (opcode == OPC_OP && funct7_alt) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op = ALU_SLL;
          F3_SLT:     alu_op = ALU_SLT;
          F3_SLTU:    alu_op = ALU_SLTU;
          F3_XOR:     alu_op = ALU_XOR;
          F3_SRL_SRA: alu_op = funct7_alt ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    alu_op = ALU_ADD;
        endcase
      end
      OPC_BRANCH: alu_op = ALU_SUB;     // Compare by subtraction
      OPC_LUI:    alu_op = ALU_PASS_B;
      default:    alu_op = ALU_ADD;
    endcase
  end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/100ps

module register_file
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
#(
  parameter bit REG_BYPASS = 1'b1
) (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  wb_to_id_t wb,
  output word_t     rd1,
  output word_t     rd2
);

  word_t regs [32];
  logic  wr_en;

  assign wr_en = wb.reg_write && (wb.rd != '0);  // x0 is never written

  // ============================================================
  // Write port
  // ============================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // ============================================================
  // Read ports
  // ============================================================

  function automatic word_t read_port(input reg_addr_t addr);
    word_t value;
    if (addr == '0)
      value = '0;
    else if (REG_BYPASS && wr_en && (wb.rd == addr))
      value = wb.data;  // Same-cycle write-through
    else
      value = regs[addr];
    return value;
  endfunction

  always_comb rd1 = read_port(rs1);
  always_comb rd2 = read_port(rs2);

endmodule

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

  // ============================================================
  // Widths with a meaning of their own
  // ============================================================

  typedef logic [31:0] word_t;      // Data or address value
  typedef logic [31:0] instr_t;     // Raw instruction word
  typedef logic [4:0]  reg_addr_t;  // x0 .. x31
  typedef logic [2:0]  funct3_t;

  // ============================================================
  // Base opcodes (bits 6:0)
  // ============================================================

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  // ALU operations seen by execute
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10   // Operand B straight through
  } alu_op_t;

  // funct3 codes shared by OP and OP_IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // The two funct7 forms of the register ALU group
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

endpackage

/* hdl/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  import rv_isa_pkg::*;

  // ============================================================
  // Control codes
  // ============================================================

  typedef enum logic [1:0] {
    RES_ALU       = 2'b00,
    RES_MEM       = 2'b01,
    RES_PC_PLUS_4 = 2'b10   // Link value of JAL and JALR
  } result_src_t;

  typedef enum logic [1:0] {
    SRC_A_REG  = 2'b00,
    SRC_A_PC   = 2'b01,
    SRC_A_ZERO = 2'b10
  } alu_src_a_t;

  typedef enum logic {
    SRC_B_REG = 1'b0,
    SRC_B_IMM = 1'b1
  } alu_src_b_t;

  typedef struct packed {
    logic        reg_write;
    result_src_t result_src;
    logic        mem_write;
    logic        jump;
    logic        branch;
    alu_src_a_t  alu_src_a;
    alu_src_b_t  alu_src_b;
    logic        illegal;
  } ctrl_t;

  // ============================================================
  // Stage packets
  // ============================================================

  typedef struct packed {
    instr_t instruction;
    word_t  pc_cur;
    word_t  pc_plus_4;
  } if_to_id_t;

  typedef struct packed {
    logic      reg_write;
    reg_addr_t rd;
    word_t     data;
  } wb_to_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    alu_op_t   alu_op;
    funct3_t   funct3;
    word_t     rd1;
    word_t     rd2;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm_ext;
    word_t     pc_cur;
    word_t     pc_plus_4;
  } id_to_ex_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decode_stage_tb \
  -f rv_decode.f -o decode_stage_sim

status=0
output=$(./obj_dir/decode_stage_sim) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && echo "$output" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

/* rv_decode.f */
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/instr_decoder.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/decode_stage.sv
tests/decode_stage_props.sv
tests/decode_stage_tb.sv

/* tests/decode_stage_props.sv */
`timescale 1ns/100ps

module decode_stage_props
  import rv_pipe_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      in_valid,
  input logic      out_valid,
  input id_to_ex_t id_to_ex
);

  // ============================================================
  // Handshake and packet rules
  // ============================================================

  a_one_cycle_latency: assert property (
    @(posedge clk) disable iff (!rst_n) in_valid |=> out_valid
  ) else $error("out_valid missing one cycle after in_valid");

  // Illegal packets carry no write effect
  a_illegal_no_write: assert property (
    @(posedge clk) disable iff (!rst_n)
      (out_valid && id_to_ex.ctrl.illegal) |->
        (!id_to_ex.ctrl.reg_write && !id_to_ex.ctrl.mem_write)
  ) else $error("illegal packet still writes a register or memory");

  a_x0_reads_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
      (out_valid && (id_to_ex.rs1 == '0)) |-> (id_to_ex.rd1 == '0)
  ) else $error("rd1 is non-zero although rs1 is x0");

endmodule

/* tests/decode_stage_tb.sv */
`timescale 1ns/100ps

module decode_stage_tb
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
();

  typedef struct packed {
    instr_t     instr;
    word_t      pc;
    word_t      rd1;
    word_t      rd2;
    word_t      imm;
    logic [3:0] alu;
    logic [9:0] ctrl;
    logic       illegal;
  } vec_t;

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  if_to_id_t if_to_id;
  wb_to_id_t wb;
  logic      out_valid;
  id_to_ex_t id_to_ex;

  vec_t      pend_q[$];         // Decodes waiting to go out back to back
  wb_to_id_t held_wb = '0;      // Writeback applied with the first strobe of a burst

  decode_stage #(
    .REG_BYPASS (1'b1)
  ) u_decode_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .if_to_id  (if_to_id),
    .wb        (wb),
    .out_valid (out_valid),
    .id_to_ex  (id_to_ex)
  );

  bind decode_stage decode_stage_props u_decode_stage_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .id_to_ex  (id_to_ex)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ============================================================
  // Checking helpers
  // ============================================================

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s is %h, expected %h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  task automatic compare_packet(input vec_t v);
    check_eq(id_to_ex.pc_cur, v.pc, "pc_cur");
    check_eq(id_to_ex.pc_plus_4, v.pc + 32'd4, "pc_plus_4");
    check_eq(id_to_ex.rd1, v.rd1, "rd1");
    check_eq(id_to_ex.rd2, v.rd2, "rd2");
    check_eq(id_to_ex.imm_ext, v.imm, "imm_ext");
    check_eq(32'(id_to_ex.alu_op), 32'(v.alu), "alu_op");
    check_eq(32'(id_to_ex.ctrl[9:1]), 32'(v.ctrl[9:1]), "ctrl");
    check_eq(32'(id_to_ex.ctrl.illegal), 32'(v.illegal), "illegal");
    check_eq(32'(id_to_ex.rs1), 32'(v.instr[19:15]), "rs1");   // Raw fields
    check_eq(32'(id_to_ex.rs2), 32'(v.instr[24:20]), "rs2");
    check_eq(32'(id_to_ex.rd), 32'(v.instr[11:7]), "rd");
    check_eq(32'(id_to_ex.funct3), 32'(v.instr[14:12]), "funct3");
  endtask

  // ============================================================
  // Drivers
  // ============================================================

  task automatic apply_writeback(input reg_addr_t rd, input word_t data);
    wb_to_id_t pkt;
    pkt.reg_write = 1'b1;
    pkt.rd        = rd;
    pkt.data      = data;
    @(posedge clk);
    wb <= pkt;
    @(posedge clk);
    wb <= '0;
  endtask

  // Strobes every queued decode on consecutive cycles and checks each output
  task automatic run_burst();
    int        n;
    int        sent;
    int        got;
    int        cyc;
    int        idle;
    if_to_id_t pkt;
    n    = pend_q.size();
    sent = 0;
    got  = 0;
    cyc  = 0;
    idle = 0;
    while (got < n) begin
      @(posedge clk);
      cyc++;
      if (sent < n) begin
        pkt.instruction = pend_q[sent].instr;
        pkt.pc_cur      = pend_q[sent].pc;
        pkt.pc_plus_4   = pend_q[sent].pc + 32'd4;
        in_valid <= 1'b1;
        if_to_id <= pkt;
        sent++;
      end else begin
        in_valid <= 1'b0;
      end
      if (cyc == 1)
        wb <= held_wb;
      else
        wb <= '0;
      @(negedge clk);
      if (out_valid) begin
        check_eq(32'(cyc), 32'(got + 2), "out_valid cycle");  // Item k lands at cycle k+2
        compare_packet(pend_q[got]);
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle >= 20) begin
          $display("out_valid never arrived");
          stop_run();
        end
      end
    end
    @(posedge clk);
    @(negedge clk);
    check_eq(32'(out_valid), 32'd0, "out_valid after burst");
    pend_q.delete();
    held_wb = '0;
  endtask

  // ============================================================
  // Main sequence
  // ============================================================

  initial begin
    int         fd;
    int         code;
    string      line;
    logic [7:0] tag;
    word_t      arg [8];
    vec_t       v;
    rst_n    <= 1'b0;
    in_valid <= 1'b0;
    if_to_id <= '0;
    wb       <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq(32'(out_valid), 32'd0, "out_valid after reset");

    fd = $fopen("tests/decode_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/decode_stim.txt");
      stop_run();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%c %h %h %h %h %h %h %h %h", tag, arg[0], arg[1], arg[2],
                       arg[3], arg[4], arg[5], arg[6], arg[7]);
        if (tag == "W" || tag == "V") begin
          if (pend_q.size() > 0)
            run_burst();
          if (tag == "W") begin
            apply_writeback(arg[0][4:0], arg[1]);
          end else begin
            held_wb.reg_write = 1'b1;
            held_wb.rd        = arg[0][4:0];
            held_wb.data      = arg[1];
          end
        end else if (tag == "D" && code == 9) begin
          v.instr   = arg[0];
          v.pc      = arg[1];
          v.rd1     = arg[2];
          v.rd2     = arg[3];
          v.imm     = arg[4];
          v.alu     = arg[5][3:0];
          v.ctrl    = arg[6][9:0];
          v.illegal = arg[7][0];
          pend_q.push_back(v);
        end else begin
          $display("stimulus file has a line that cannot be read: %s", line);
          stop_run();
        end
      end
    end
    if (pend_q.size() > 0)
      run_burst();
    $fclose(fd);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* tests/decode_stim.txt */
# W rd data = writeback for one cycle, V rd data = writeback in the cycle of the next decode
# D instr pc rd1 rd2 imm_ext alu_op ctrl illegal, all hex; adjacent D lines go back to back
D 002081b3 00000000 00000000 00000000 00000000 0 200 0
W 01 12345678
W 02 0000abcd
W 00 deadbeef
D 002081b3 00000100 12345678 0000abcd 00000000 0 200 0
D 40208233 00000104 12345678 0000abcd 00000000 1 200 0
D 002002b3 00000108 00000000 0000abcd 00000000 0 200 0
V 02 00005555
D 00208333 0000010c 12345678 00005555 00000000 0 200 0
D ffb08393 00000110 12345678 00000000 fffffffb 0 202 0
D fe20aa23 00000114 12345678 00005555 fffffff4 0 042 0
D fe2088e3 00000118 12345678 00005555 fffffff0 1 010 0
D abcde437 0000011c 00000000 00000000 abcde000 a 20a 0
D ffdff4ef 00000120 00000000 00000000 fffffffc 0 326 0
D 0040a503 00000124 12345678 00000000 00000004 0 282 0
D 000100e7 00000128 00005555 00000000 00000000 0 322 0
D 12345597 0000012c 00000000 00000000 12345000 0 206 0
D 00209463 00000130 12345678 00005555 00000008 1 010 0
D 0000007f 00000134 00000000 00000000 00000000 0 001 1
D 02208633 00000138 12345678 00005555 00000000 0 001 1
D 0100f683 0000013c 12345678 00000000 00000010 0 083 1
